// ==== rtl/spi_mem_pkg.sv ====
package spi_mem_pkg;

    // bus side types.
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_TWORD = 2'd2
    } bus_size_e;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_rw_e;

    typedef struct packed {
        logic      req;
        bus_rw_e   rw;
        bus_size_e size;
        bus_addr_t addr;
        bus_data_t data;
    } sport_in_t;

    typedef struct packed {
        logic      ack;
        logic      seqslv;
        bus_data_t data;
    } sport_out_t;

    // memory side types.
    typedef logic [3:0] nibble_t;
    typedef logic [7:0] cmd_t;

    // number of bytes already captured in the current read word.
    typedef logic [1:0] byte_cnt_t;

    localparam cmd_t CMD_READ  = 8'h0A;
    localparam cmd_t CMD_WRITE = 8'h02;

    // initial latency in memory clocks, then strobe pulses ahead of read data.
    localparam int LATENCY_COUNT = 7;
    localparam int PRE_CYCLES    = 3;

endpackage

// ==== rtl/spi_mem_ctrl.sv ====
`timescale 1ns/1ns

module spi_mem_ctrl #(
    parameter spi_mem_pkg::bus_addr_t BASE_ADDR = '0,
    parameter int                     MEM_BYTES = 1024
) (
    input  logic                    clk_i,
    input  logic                    nrst_i,

    input  spi_mem_pkg::sport_in_t  sport_i,
    output spi_mem_pkg::sport_out_t sport_o,

    output logic                    spi_clk_o,
    output logic                    spi_cs_o,
    output spi_mem_pkg::nibble_t    spi_mosi_o,
    input  logic                    spi_dqsm_i,
    output logic                    spi_dqsm_o,

    output logic                    capture_en_o,
    input  spi_mem_pkg::bus_data_t  rx_word_i,
    input  spi_mem_pkg::byte_cnt_t  rx_bytes_i,
    input  logic                    word_ready_i
);

    import spi_mem_pkg::*;

    localparam int LAT_W = $clog2(LATENCY_COUNT);
    localparam int PRE_W = $clog2(PRE_CYCLES);

    localparam logic [LAT_W-1:0] LAT_FULL = LAT_W'(LATENCY_COUNT - 1);
    // reads start watching the strobe a little before the device drives it.
    localparam logic [LAT_W-1:0] LAT_READ = LAT_W'(LATENCY_COUNT - 3);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRE_CYCLES - 1);

    typedef enum logic [3:0] {
        ST_READY,
        ST_SETUP,
        ST_CMD,
        ST_ADDR,
        ST_LATENCY,
        ST_PRE,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE,
        ST_WRITE_DELAY,
        ST_DONE
    } state_e;

    state_e           state;
    bus_addr_t        rel_addr;
    logic             in_window;
    logic [31:0]      ca_word;
    cmd_t             cmd;
    logic             clk_en;
    logic [2:0]       nib_cnt;
    logic [LAT_W-1:0] lat_cnt;
    logic             lat_dbl;
    logic [PRE_W-1:0] pre_cnt;
    logic             dqsm_q;
    logic [1:0]       word_cnt;
    logic             last_nibble;
    logic             seqslv_q;
    bus_data_t        rd_data;
    bus_data_t        wr_buf;

    assign rel_addr  = sport_i.addr - BASE_ADDR;
    assign in_window = rel_addr < bus_addr_t'(MEM_BYTES);

    // row in bits 28:16 and byte column in bits 14:5 of the address phase.
    assign ca_word = {3'b000, rel_addr[22:10], 1'b0, rel_addr[9:0], 5'b00000};
    assign cmd     = (sport_i.rw == BUS_READ) ? CMD_READ : CMD_WRITE;

    always_comb begin
        case (sport_i.size)
            SIZE_BYTE:  last_nibble = (nib_cnt == 3'd1);
            SIZE_TWORD: last_nibble = (nib_cnt == 3'd7) && (word_cnt == 2'd2);
            default:    last_nibble = (nib_cnt == 3'd7);
        endcase
    end

    assign sport_o.ack    = !(state inside {ST_READY, ST_SETUP, ST_DONE});
    assign sport_o.seqslv = seqslv_q;
    assign sport_o.data   = rd_data;

    assign spi_cs_o     = (state == ST_READY) || (state == ST_DONE);
    assign capture_en_o = (state == ST_READ) || (state == ST_READ_WAIT);
    // the mask is never used.
    assign spi_dqsm_o   = 1'b0;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state      <= ST_READY;
            clk_en     <= 1'b0;
            spi_mosi_o <= '0;
            nib_cnt    <= '0;
            lat_cnt    <= '0;
            lat_dbl    <= 1'b0;
            pre_cnt    <= '0;
            dqsm_q     <= 1'b0;
            word_cnt   <= '0;
            seqslv_q   <= 1'b0;
        end else begin
            dqsm_q   <= spi_dqsm_i;
            seqslv_q <= 1'b0;

            case (state)
                ST_READY: begin
                    clk_en     <= 1'b0;
                    spi_mosi_o <= '0;
                    nib_cnt    <= '0;
                    lat_dbl    <= 1'b0;
                    pre_cnt    <= '0;
                    word_cnt   <= '0;
                    if (sport_i.req && in_window) begin
                        state <= ST_SETUP;
                    end
                end

                ST_SETUP: begin
                    clk_en     <= 1'b1;
                    spi_mosi_o <= cmd[7:4];
                    state      <= ST_CMD;
                end

                ST_CMD: begin
                    spi_mosi_o <= cmd[3:0];
                    state      <= ST_ADDR;
                end

                ST_ADDR: begin
                    spi_mosi_o <= ca_word[5'd28 - {nib_cnt, 2'b00} +: 4];
                    nib_cnt    <= nib_cnt + 3'd1;
                    if (nib_cnt == 3'd7) begin
                        // a high strobe during the address asks for twice the latency.
                        lat_dbl <= spi_dqsm_i;
                        lat_cnt <= (sport_i.rw == BUS_READ) ? LAT_READ : LAT_FULL;
                        state   <= ST_LATENCY;
                    end
                end

                ST_LATENCY: begin
                    spi_mosi_o <= '0;
                    if (spi_clk_o) begin
                        if (lat_cnt != '0) begin
                            lat_cnt <= lat_cnt - 1'b1;
                        end else if (lat_dbl) begin
                            lat_dbl <= 1'b0;
                            lat_cnt <= LAT_FULL;
                        end else if (sport_i.rw == BUS_WRITE) begin
                            wr_buf <= sport_i.data;
                            state  <= ST_WRITE;
                        end else begin
                            state <= ST_PRE;
                        end
                    end
                end

                ST_PRE: begin
                    if (spi_dqsm_i && !dqsm_q) begin
                        pre_cnt <= pre_cnt + 1'b1;
                        if (pre_cnt == PRE_LAST) begin
                            state <= ST_READ;
                        end
                    end
                end

                ST_READ: begin
                    case (sport_i.size)
                        SIZE_BYTE: begin
                            if (rx_bytes_i == 2'd1) begin
                                rd_data <= {24'd0, rx_word_i[7:0]};
                                clk_en  <= 1'b0;
                                state   <= ST_DONE;
                            end
                        end
                        SIZE_TWORD: begin
                            if (word_ready_i) begin
                                rd_data  <= rx_word_i;
                                seqslv_q <= 1'b1;
                                state    <= ST_READ_WAIT;
                            end
                        end
                        default: begin
                            if (word_ready_i) begin
                                rd_data <= rx_word_i;
                                clk_en  <= 1'b0;
                                state   <= ST_DONE;
                            end
                        end
                    endcase
                end

                // word_ready stays high for one more cycle, so skip it here.
                ST_READ_WAIT: begin
                    if (word_cnt == 2'd2) begin
                        clk_en <= 1'b0;
                        state  <= ST_DONE;
                    end else begin
                        word_cnt <= word_cnt + 2'd1;
                        state    <= ST_READ;
                    end
                end

                ST_WRITE: begin
                    spi_mosi_o <= wr_buf[{nib_cnt, 2'b00} +: 4];
                    nib_cnt    <= nib_cnt + 3'd1;
                    // ask for the next burst word well before it is loaded.
                    if (sport_i.size == SIZE_TWORD && nib_cnt == 3'd1) begin
                        seqslv_q <= 1'b1;
                    end
                    if (sport_i.size == SIZE_TWORD && nib_cnt == 3'd7 && !last_nibble) begin
                        wr_buf   <= sport_i.data;
                        word_cnt <= word_cnt + 2'd1;
                    end
                    if (last_nibble) begin
                        state <= ST_WRITE_DELAY;
                    end
                end

                ST_WRITE_DELAY: begin
                    spi_mosi_o <= '0;
                    clk_en     <= 1'b0;
                    state      <= ST_DONE;
                end

                ST_DONE: begin
                    clk_en <= 1'b0;
                    if (!sport_i.req) begin
                        state <= ST_READY;
                    end
                end

                default: begin
                    state <= ST_READY;
                end
            endcase
        end
    end

    // memory clock edges land between the rising edges that update mosi.
    always_ff @(negedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            spi_clk_o <= 1'b0;
        end else if (clk_en) begin
            spi_clk_o <= ~spi_clk_o;
        end else begin
            spi_clk_o <= 1'b0;
        end
    end

endmodule

// ==== rtl/spi_mem_rx.sv ====
`timescale 1ns/1ns

module spi_mem_rx (
    input  logic                   spi_dqsm_i,
    input  spi_mem_pkg::nibble_t   spi_miso_i,
    input  logic                   capture_en_i,
    output spi_mem_pkg::bus_data_t rx_word_o,
    output spi_mem_pkg::byte_cnt_t rx_bytes_o,
    output logic                   word_ready_o
);

    import spi_mem_pkg::*;

    nibble_t [3:0] hi_q;
    nibble_t [3:0] lo_q;
    byte_cnt_t     byte_q;

    // the device sends the high nibble of each byte on the falling strobe.
    always_ff @(negedge spi_dqsm_i) begin
        if (!capture_en_i) begin
            hi_q <= '0;
        end else begin
            hi_q[byte_q] <= spi_miso_i;
        end
    end

    // the low nibble follows on the rising strobe and completes the byte.
    always_ff @(posedge spi_dqsm_i) begin
        if (!capture_en_i) begin
            lo_q         <= '0;
            byte_q       <= '0;
            word_ready_o <= 1'b0;
        end else begin
            lo_q[byte_q] <= spi_miso_i;
            byte_q       <= byte_q + 1'b1;
            word_ready_o <= (byte_q == 2'd3);
        end
    end

    // byte k of the stream goes to bits 8k and up.
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rx_word_o[8*k +: 8] = {hi_q[k], lo_q[k]};
        end
    end

    assign rx_bytes_o = byte_q;

endmodule

// ==== rtl/spi_mem_top.sv ====
`timescale 1ns/1ns

module spi_mem_top #(
    parameter spi_mem_pkg::bus_addr_t BASE_ADDR = 32'h4000_0000,
    parameter int                     MEM_BYTES = 4096
) (
    input  logic                    clk_i,
    input  logic                    nrst_i,

    input  spi_mem_pkg::sport_in_t  sport_i,
    output spi_mem_pkg::sport_out_t sport_o,

    output logic                    spi_clk_o,
    output logic                    spi_cs_o,
    output spi_mem_pkg::nibble_t    spi_mosi_o,
    input  spi_mem_pkg::nibble_t    spi_miso_i,
    input  logic                    spi_dqsm_i,
    output logic                    spi_dqsm_o
);

    import spi_mem_pkg::*;

    logic      capture_en;
    bus_data_t rx_word;
    byte_cnt_t rx_bytes;
    logic      word_ready;

    spi_mem_ctrl #(
        .BASE_ADDR (BASE_ADDR),
        .MEM_BYTES (MEM_BYTES)
    ) u_ctrl (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .sport_i      (sport_i),
        .sport_o      (sport_o),
        .spi_clk_o    (spi_clk_o),
        .spi_cs_o     (spi_cs_o),
        .spi_mosi_o   (spi_mosi_o),
        .spi_dqsm_i   (spi_dqsm_i),
        .spi_dqsm_o   (spi_dqsm_o),
        .capture_en_o (capture_en),
        .rx_word_i    (rx_word),
        .rx_bytes_i   (rx_bytes),
        .word_ready_i (word_ready)
    );

    spi_mem_rx u_rx (
        .spi_dqsm_i   (spi_dqsm_i),
        .spi_miso_i   (spi_miso_i),
        .capture_en_i (capture_en),
        .rx_word_o    (rx_word),
        .rx_bytes_o   (rx_bytes),
        .word_ready_o (word_ready)
    );

endmodule

// ==== test/spi_mem_tb_clock.sv ====
`timescale 1ns/1ns

module spi_mem_tb_clock (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // reset is held for eight cycles and released just after a rising edge.
    initial begin
        nrst_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #5;
        nrst_o = 1'b1;
    end

endmodule

// ==== test/psram_model.sv ====
`timescale 1ns/1ns

module psram_model #(
    parameter int MEM_BYTES = 4096
) (
    input  logic                 spi_clk_i,
    input  logic                 spi_cs_i,
    input  spi_mem_pkg::nibble_t spi_mosi_i,
    output spi_mem_pkg::nibble_t spi_miso_o,
    output logic                 spi_dqsm_o
);

    import spi_mem_pkg::*;

    // two command edges and eight address edges come before the latency.
    localparam int DATA_EDGE = 10 + 2 * LATENCY_COUNT;
    // the falling half of the last preamble pulse already carries read data.
    localparam int READ_EDGE = DATA_EDGE + 2 * PRE_CYCLES - 1;

    logic [7:0]  mem [MEM_BYTES];
    cmd_t        cmd;
    logic [31:0] ca_word;
    logic        strobe_edge;
    int          edge_cnt;
    int          base;
    int          n;
    int          idx;

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        spi_miso_o = '0;
        spi_dqsm_o = 1'b0;
        edge_cnt   = 0;
    end

    always @(posedge spi_cs_i) begin
        edge_cnt   = 0;
        spi_miso_o = '0;
        spi_dqsm_o = 1'b0;
    end

    always @(spi_clk_i) begin
        if (spi_cs_i === 1'b0) begin
            strobe_edge = 1'b0;
            if (edge_cnt < 2) begin
                cmd = {cmd[3:0], spi_mosi_i};
            end else if (edge_cnt < 10) begin
                ca_word = {ca_word[27:0], spi_mosi_i};
                base    = int'({ca_word[28:16], ca_word[14:5]}) % MEM_BYTES;
            end else if (cmd == CMD_WRITE && edge_cnt >= DATA_EDGE) begin
                n   = edge_cnt - DATA_EDGE;
                idx = (base + n / 2) % MEM_BYTES;
                // the low nibble of each byte arrives first.
                if (n % 2 == 0) begin
                    mem[idx][3:0] = spi_mosi_i;
                end else begin
                    mem[idx][7:4] = spi_mosi_i;
                end
            end else if (cmd == CMD_READ && edge_cnt >= DATA_EDGE) begin
                strobe_edge = 1'b1;
                if (edge_cnt >= READ_EDGE) begin
                    n          = edge_cnt - READ_EDGE;
                    idx        = (base + n / 2) % MEM_BYTES;
                    spi_miso_o = (n % 2 == 0) ? mem[idx][7:4] : mem[idx][3:0];
                end
            end
            edge_cnt++;
            // the strobe follows the memory clock a little after the data settles.
            if (strobe_edge) begin
                #10;
                spi_dqsm_o = spi_clk_i;
            end
        end
    end

endmodule

// ==== test/spi_mem_tb.sv ====
`timescale 1ns/1ns

module spi_mem_tb;

    import spi_mem_pkg::*;

    localparam bus_addr_t BASE_ADDR  = 32'h4000_0000;
    localparam int        MEM_BYTES  = 4096;
    // about fifty transfers of under a hundred cycles each plus a 200 cycle idle test.
    localparam int        MAX_CYCLES = 20000;

    logic       clk;
    logic       nrst;
    sport_in_t  sport_in;
    sport_out_t sport_out;
    logic       spi_clk;
    logic       spi_cs;
    nibble_t    spi_mosi;
    nibble_t    spi_miso;
    logic       spi_dqsm;
    logic       spi_mask;

    logic [7:0]      sb [MEM_BYTES];
    bus_data_t [2:0] rd_words;
    int              seq_pulses;
    int              errors;
    int              test_start;
    int              tests_ok;
    int              tests_bad;
    int              cycles = 0;
    int              seed;

    spi_mem_tb_clock u_clock (
        .clk_o  (clk),
        .nrst_o (nrst)
    );

    spi_mem_top #(
        .BASE_ADDR (BASE_ADDR),
        .MEM_BYTES (MEM_BYTES)
    ) UUT (
        .clk_i      (clk),
        .nrst_i     (nrst),
        .sport_i    (sport_in),
        .sport_o    (sport_out),
        .spi_clk_o  (spi_clk),
        .spi_cs_o   (spi_cs),
        .spi_mosi_o (spi_mosi),
        .spi_miso_i (spi_miso),
        .spi_dqsm_i (spi_dqsm),
        .spi_dqsm_o (spi_mask)
    );

    psram_model #(
        .MEM_BYTES (MEM_BYTES)
    ) u_mem (
        .spi_clk_i  (spi_clk),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .spi_dqsm_o (spi_dqsm)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic close_test(input string name);
        if (errors == test_start) begin
            $display("ok     %s", name);
            tests_ok++;
        end else begin
            $display("error  %s: %0d mismatches", name, errors - test_start);
            tests_bad++;
        end
        test_start = errors;
    endtask

    // memory byte A+k sits in bus bits 8k and up.
    function automatic bus_data_t expected_word(input bus_addr_t addr);
        int base;
        base = int'(addr - BASE_ADDR);
        return {sb[base + 3], sb[base + 2], sb[base + 1], sb[base]};
    endfunction

    task automatic note_write(input bus_addr_t addr, input bus_data_t data, input int nbytes);
        int base;
        base = int'(addr - BASE_ADDR);
        for (int k = 0; k < nbytes; k++) begin
            sb[base + k] = data[8*k +: 8];
        end
    endtask

    // burst words are handed over or collected on each seqslv pulse.
    task automatic bus_access(input bus_rw_e rw, input bus_size_e size, input bus_addr_t addr,
                              input bus_data_t [2:0] wr_words);
        int next_word;
        int waited;
        next_word     = 1;
        seq_pulses    = 0;
        rd_words      = '0;
        sport_in.req  = 1'b1;
        sport_in.rw   = rw;
        sport_in.size = size;
        sport_in.addr = addr;
        sport_in.data = wr_words[0];
        tick();
        waited = 1;
        while (sport_out.ack !== 1'b1) begin
            tick();
            waited++;
        end
        if (waited != 2) begin
            report_mismatch("cycles from req to sport_o.ack", 32'd2, waited);
        end
        while (sport_out.ack === 1'b1) begin
            tick();
            if (sport_out.seqslv === 1'b1) begin
                if (rw == BUS_READ && seq_pulses < 3) begin
                    rd_words[seq_pulses] = sport_out.data;
                end
                if (rw == BUS_WRITE && next_word < 3) begin
                    sport_in.data = wr_words[next_word];
                    next_word++;
                end
                seq_pulses++;
            end
        end
        if (size != SIZE_TWORD) begin
            rd_words[0] = sport_out.data;
        end
        sport_in.req = 1'b0;
        tick();
    endtask

    task automatic check_reset_state();
        if (sport_out.ack !== 1'b0) report_mismatch("sport_o.ack", 32'd0, sport_out.ack);
        if (sport_out.seqslv !== 1'b0) report_mismatch("sport_o.seqslv", 32'd0, sport_out.seqslv);
        if (spi_cs !== 1'b1) report_mismatch("spi_cs_o", 32'd1, spi_cs);
        if (spi_clk !== 1'b0) report_mismatch("spi_clk_o", 32'd0, spi_clk);
        if (spi_mosi !== 4'h0) report_mismatch("spi_mosi_o", 32'd0, spi_mosi);
        if (spi_mask !== 1'b0) report_mismatch("spi_dqsm_o", 32'd0, spi_mask);
        repeat (20) begin
            tick();
            if (spi_cs !== 1'b1) report_mismatch("spi_cs_o", 32'd1, spi_cs);
        end
        close_test("reset values and idle chip select");
    endtask

    task automatic word_write_read();
        bus_addr_t addr;
        bus_data_t data;
        int        base;
        addr = BASE_ADDR + 32'h100;
        data = 32'hA1B2_C3D4;
        base = int'(addr - BASE_ADDR);
        bus_access(BUS_WRITE, SIZE_WORD, addr, {64'd0, data});
        note_write(addr, data, 4);
        for (int k = 0; k < 4; k++) begin
            if (u_mem.mem[base + k] !== data[8*k +: 8]) begin
                report_mismatch("psram byte", data[8*k +: 8], u_mem.mem[base + k]);
            end
        end
        bus_access(BUS_READ, SIZE_WORD, addr, '0);
        if (rd_words[0] !== expected_word(addr)) begin
            report_mismatch("sport_o.data", expected_word(addr), rd_words[0]);
        end
        close_test("word write and read back");
    endtask

    task automatic byte_write_read();
        bus_addr_t  addr;
        logic [7:0] vals [4];
        addr = BASE_ADDR + 32'h204;
        vals = '{8'h5C, 8'hE7, 8'h19, 8'hA2};
        for (int k = 0; k < 4; k++) begin
            bus_access(BUS_WRITE, SIZE_BYTE, addr + k, {64'd0, 24'd0, vals[k]});
            note_write(addr + k, {24'd0, vals[k]}, 1);
        end
        bus_access(BUS_READ, SIZE_WORD, addr, '0);
        if (rd_words[0] !== expected_word(addr)) begin
            report_mismatch("sport_o.data", expected_word(addr), rd_words[0]);
        end
        bus_access(BUS_READ, SIZE_BYTE, addr + 2, '0);
        if (rd_words[0] !== {24'd0, sb[int'(addr - BASE_ADDR) + 2]}) begin
            report_mismatch("sport_o.data", {24'd0, sb[int'(addr - BASE_ADDR) + 2]}, rd_words[0]);
        end
        close_test("byte writes and byte read");
    endtask

    task automatic burst_write_read();
        bus_addr_t       addr;
        bus_data_t [2:0] words;
        addr  = BASE_ADDR + 32'h300;
        words = {32'h5A5A_A5A5, 32'h89AB_CDEF, 32'h0123_4567};
        bus_access(BUS_WRITE, SIZE_TWORD, addr, words);
        for (int n = 0; n < 3; n++) begin
            note_write(addr + 4 * n, words[n], 4);
        end
        bus_access(BUS_READ, SIZE_TWORD, addr, '0);
        if (seq_pulses != 3) report_mismatch("sport_o.seqslv pulses", 32'd3, seq_pulses);
        for (int n = 0; n < 3; n++) begin
            if (rd_words[n] !== expected_word(addr + 4 * n)) begin
                report_mismatch("sport_o.data", expected_word(addr + 4 * n), rd_words[n]);
            end
        end
        close_test("three word burst write and read");
    endtask

    task automatic out_of_window_request();
        sport_in.req  = 1'b1;
        sport_in.rw   = BUS_READ;
        sport_in.size = SIZE_WORD;
        sport_in.addr = BASE_ADDR + MEM_BYTES;
        repeat (200) begin
            tick();
            if (sport_out.ack !== 1'b0) report_mismatch("sport_o.ack", 32'd0, sport_out.ack);
            if (spi_cs !== 1'b1) report_mismatch("spi_cs_o", 32'd1, spi_cs);
        end
        sport_in.req = 1'b0;
        tick();
        close_test("address outside the window");
    endtask

    task automatic random_word_traffic();
        bus_addr_t addr;
        bus_data_t data;
        repeat (20) begin
            addr = BASE_ADDR + ($urandom % (MEM_BYTES / 4)) * 4;
            data = $urandom;
            bus_access(BUS_WRITE, SIZE_WORD, addr, {64'd0, data});
            note_write(addr, data, 4);
            bus_access(BUS_READ, SIZE_WORD, addr, '0);
            if (rd_words[0] !== expected_word(addr)) begin
                report_mismatch("sport_o.data", expected_word(addr), rd_words[0]);
            end
        end
        close_test("random word writes and reads");
    endtask

    initial begin
        seed = 87;
        void'($urandom(seed));
        errors     = 0;
        test_start = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        sport_in   = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            sb[i] = 8'h00;
        end
        wait (nrst === 1'b1);
        tick();
        check_reset_state();
        word_write_read();
        byte_write_read();
        burst_write_read();
        out_of_window_request();
        random_word_traffic();
        $display("tests ok %0d, tests with errors %0d, mismatches %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== spi_mem_top.f ====
rtl/spi_mem_pkg.sv
rtl/spi_mem_ctrl.sv
rtl/spi_mem_rx.sv
rtl/spi_mem_top.sv
test/spi_mem_tb_clock.sv
test/psram_model.sv
test/spi_mem_tb.sv
